// File: tests/golden_vectors.hex
// columns: kind, then address or key, then data or expected value, all hex
// kind 1 load (byte addr, host word), 2 readback (rom index, low 12 bits), 3 keys (cont1_key, input_k0)
1 00000000 1abc2def
1 00000004 0123f456
1 00003ffc 7fff8001
1 00001230 cafe5a5a
// outside the rom region, these must not land
1 10000004 ffffffff
1 f0000000 00000000
2 00000000 00000abc
2 00000001 00000def
2 00000002 00000123
2 00000003 00000456
2 00001ffe 00000fff
2 00001fff 00000001
2 00000918 00000afe
2 00000919 00000a5a
3 00000000 7
3 00000010 3
3 00000020 5
3 00000040 6
3 00000070 0
3 0000ff8f 7
3 00000050 2
0 00000000 00000000

// File: files.f
hw/calc_pkg.sv
hw/core_tick_gen.sv
hw/rom_loader.sv
hw/rom_store.sv
hw/key_conditioner.sv
hw/video_timing.sv
hw/calc_core_top.sv
tests/calc_checker.sv
tests/tb_calc_core_top.sv

// File: Bender.yml
package:
  name: calc_core

sources:
  - files:
      - hw/calc_pkg.sv
      - hw/core_tick_gen.sv
      - hw/rom_loader.sv
      - hw/rom_store.sv
      - hw/key_conditioner.sv
      - hw/video_timing.sv
      - hw/calc_core_top.sv
  - target: test
    files:
      - tests/calc_checker.sv
      - tests/tb_calc_core_top.sv

// File: tests/tb_calc_core_top.sv
// testbench for the calculator core support fabric
// replays golden load, readback and key records against the DUT,
// feeds pixel data and leaves the comparing to the monitor

module tb_calc_core_top;

  localparam int div_reload = 100;
  localparam int h_total    = 40;
  localparam int h_active   = 24;
  localparam int h_bporch   = 4;
  localparam int v_total    = 20;
  localparam int v_active   = 12;
  localparam int v_bporch   = 2;

  logic        clk_3_276mhz;
  logic        reset_n;
  logic        load_req;
  logic [31:0] load_addr;
  logic [31:0] load_data;
  logic        load_ack;
  logic        core_tick;
  logic        core_tick_2x;
  logic [12:0] rom_addr;
  logic [11:0] rom_data;
  logic [15:0] cont1_key;
  logic [3:0]  input_k0;
  logic [7:0]  video_addr;
  logic [3:0]  video_data;
  logic [23:0] video_rgb;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;

  // expectation strobes into the monitor
  logic        rom_chk;
  logic        key_chk;
  logic [11:0] exp_value;

  logic [7:0]  pix_lfsr;
  // three words per record: kind, address or key, data or expected
  logic [31:0] gold [0:95];
  int          check_errors;
  int          tb_errors;
  int          loads;
  int          readbacks;
  int          key_checks;

  calc_core_top #(
    .div_reload (div_reload),
    .h_total    (h_total),
    .h_active   (h_active),
    .h_bporch   (h_bporch),
    .v_total    (v_total),
    .v_active   (v_active),
    .v_bporch   (v_bporch)
  ) dut (
    .clk_3_276mhz (clk_3_276mhz),
    .reset_n      (reset_n),
    .load_req     (load_req),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .load_ack     (load_ack),
    .core_tick    (core_tick),
    .core_tick_2x (core_tick_2x),
    .rom_addr     (rom_addr),
    .rom_data     (rom_data),
    .cont1_key    (cont1_key),
    .input_k0     (input_k0),
    .video_addr   (video_addr),
    .video_data   (video_data),
    .video_rgb    (video_rgb),
    .video_de     (video_de),
    .video_hs     (video_hs),
    .video_vs     (video_vs)
  );

  calc_checker #(
    .div_reload (div_reload),
    .h_total    (h_total),
    .h_active   (h_active),
    .v_total    (v_total),
    .v_active   (v_active)
  ) u_check (
    .clk_3_276mhz (clk_3_276mhz),
    .reset_n      (reset_n),
    .load_req     (load_req),
    .load_ack     (load_ack),
    .core_tick    (core_tick),
    .core_tick_2x (core_tick_2x),
    .rom_data     (rom_data),
    .rom_chk      (rom_chk),
    .input_k0     (input_k0),
    .key_chk      (key_chk),
    .exp_value    (exp_value),
    .video_data   (video_data),
    .video_addr   (video_addr),
    .video_rgb    (video_rgb),
    .video_de     (video_de),
    .video_hs     (video_hs),
    .video_vs     (video_vs),
    .error_count  (check_errors)
  );

  ////////////////////////////////////////
  // clock and pixel data
  ////////////////////////////////////////

  always #2 clk_3_276mhz = ~clk_3_276mhz;

  // lfsr pixel data, zero for roughly half the pixels
  always @(posedge clk_3_276mhz) begin
    pix_lfsr   <= {pix_lfsr[6:0], pix_lfsr[7] ^ pix_lfsr[5] ^ pix_lfsr[4] ^ pix_lfsr[3]};
    video_data <= pix_lfsr[4] ? pix_lfsr[3:0] : 4'h0;
  end

  ////////////////////////////////////////
  // record handlers
  ////////////////////////////////////////

  // counts core ticks, gives up after a generous bound
  task automatic wait_ticks(input int count);
    int seen;
    int n;
    seen = 0;
    n    = 0;
    while (seen < count && n < count * (div_reload + 20)) begin
      @(posedge clk_3_276mhz);
      n++;
      if (core_tick) seen++;
    end
    if (seen < count) begin
      $display("timeout: core_tick stopped pulsing");
      tb_errors++;
    end
  endtask

  // one four phase host write, random idle gap before it
  task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
    int n;
    repeat ($urandom % 8) @(posedge clk_3_276mhz);
    load_addr <= addr;
    load_data <= data;
    load_req  <= 1'b1;
    n = 0;
    @(posedge clk_3_276mhz);
    while (!load_ack && n < 16) begin
      @(posedge clk_3_276mhz);
      n++;
    end
    if (!load_ack) begin
      $display("timeout: load_ack never rose for address %h", addr);
      tb_errors++;
    end
    // host may sit on req a little after ack
    repeat ($urandom % 3) @(posedge clk_3_276mhz);
    load_req <= 1'b0;
    n = 0;
    @(posedge clk_3_276mhz);
    while (load_ack && n < 16) begin
      @(posedge clk_3_276mhz);
      n++;
    end
    if (load_ack) begin
      $display("timeout: load_ack stayed high for address %h", addr);
      tb_errors++;
    end
    loads++;
  endtask

  // address up, one tick to latch, then strobe the monitor
  task automatic read_back(input logic [12:0] idx, input logic [11:0] expected);
    rom_addr <= idx;
    wait_ticks(1);
    exp_value <= expected;
    rom_chk   <= 1'b1;
    @(posedge clk_3_276mhz);
    rom_chk   <= 1'b0;
    readbacks++;
  endtask

  // keys held for five ticks, past the three stage latency
  task automatic apply_keys(input logic [15:0] keys, input logic [3:0] expected);
    cont1_key <= keys;
    wait_ticks(5);
    exp_value <= {8'h00, expected};
    key_chk   <= 1'b1;
    @(posedge clk_3_276mhz);
    key_chk   <= 1'b0;
    key_checks++;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : run_test
    int          rec;
    int          idx;
    void'($urandom(31494));
    clk_3_276mhz = 1'b0;
    reset_n      = 1'b0;
    load_req     = 1'b0;
    load_addr    = 32'h0;
    load_data    = 32'h0;
    rom_addr     = 13'h0;
    cont1_key    = 16'h0;
    video_data   = 4'h0;
    pix_lfsr     = 8'h5a;
    rom_chk      = 1'b0;
    key_chk      = 1'b0;
    exp_value    = 12'h0;
    tb_errors    = 0;
    loads        = 0;
    readbacks    = 0;
    key_checks   = 0;
    $readmemh("tests/golden_vectors.hex", gold);

    repeat (3) @(posedge clk_3_276mhz);
    reset_n <= 1'b1;
    repeat (4) @(posedge clk_3_276mhz);

    rec = 0;
    idx = 0;
    while (rec < 32 && tb_errors == 0 &&
           (gold[idx] == 32'd1 || gold[idx] == 32'd2 || gold[idx] == 32'd3)) begin
      case (gold[idx])
        32'd1:   host_write(gold[idx+1], gold[idx+2]);
        32'd2:   read_back(gold[idx+1][12:0], gold[idx+2][11:0]);
        default: apply_keys(gold[idx+1][15:0], gold[idx+2][3:0]);
      endcase
      rec++;
      idx = idx + 3;
    end
    if (rec == 0) begin
      $display("no golden records could be read");
      tb_errors++;
    end
    repeat (4) @(posedge clk_3_276mhz);

    $display("checker errors %0d, testbench errors %0d, loads %0d, readbacks %0d, keys %0d",
             check_errors, tb_errors, loads, readbacks, key_checks);
    if (check_errors == 0 && tb_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/calc_checker.sv
// testbench monitor for the calculator core support fabric
// compares DUT ports against golden expectations and against the
// tick, handshake, key and video timing rules

module calc_checker #(
  parameter int div_reload = 100,
  parameter int h_total    = 400,
  parameter int h_active   = 320,
  parameter int v_total    = 512,
  parameter int v_active   = 240
) (
  input  logic        clk_3_276mhz,
  input  logic        reset_n,
  input  logic        load_req,
  input  logic        load_ack,
  input  logic        core_tick,
  input  logic        core_tick_2x,
  input  logic [11:0] rom_data,
  input  logic        rom_chk,
  input  logic [3:0]  input_k0,
  input  logic        key_chk,
  input  logic [11:0] exp_value,
  input  logic [3:0]  video_data,
  input  logic [7:0]  video_addr,
  input  logic [23:0] video_rgb,
  input  logic        video_de,
  input  logic        video_hs,
  input  logic        video_vs,
  output int          error_count
);

  // lit pixel, 0x3c per channel
  localparam logic [23:0] grey = 24'h3c3c3c;

  int          cyc;
  int          req_edge;
  int          low_edge;
  int          last_tick;
  int          last_hs;
  int          last_vs;
  int          fast_ticks;
  int          de_cycles;
  logic        reset_done;
  logic        req_q;
  logic        ack_q;
  logic [3:0]  data_q;
  logic [7:0]  addr_q;
  logic [7:0]  next_addr;
  logic [23:0] exp_rgb;

  initial begin
    error_count = 0;
    cyc         = 0;
    req_edge    = 0;
    low_edge    = 0;
    last_tick   = -1;
    last_hs     = -1;
    last_vs     = -1;
    fast_ticks  = 0;
    de_cycles   = 0;
    reset_done  = 1'b0;
    req_q       = 1'b0;
    ack_q       = 1'b0;
    data_q      = 4'h0;
    addr_q      = 8'h00;
  end

  task automatic flag_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    error_count++;
  endtask

  // samples are the values held during the cycle before each edge
  always @(posedge clk_3_276mhz) begin
    cyc++;
    if (cyc > 1 && (!reset_n || !reset_done)) begin
      // in reset and on the first cycle out of it
      if ({load_ack, core_tick, core_tick_2x, video_de, video_hs, video_vs} !== 6'b0)
        flag_mismatch("{load_ack,core_tick,core_tick_2x,video_de,video_hs,video_vs}",
                      0, {load_ack, core_tick, core_tick_2x, video_de, video_hs, video_vs});
      if (video_rgb !== 24'h0) flag_mismatch("video_rgb in reset", 0, video_rgb);
      if (video_addr !== 8'h00) flag_mismatch("video_addr in reset", 0, video_addr);
      if (input_k0 !== 4'h0) flag_mismatch("input_k0 in reset", 0, input_k0);
      if (reset_n) reset_done = 1'b1;
    end else if (reset_n) begin
      ////////////////////////////////////////
      // host handshake
      ////////////////////////////////////////
      if (load_req && !req_q && !load_ack) req_edge = cyc;
      if (load_ack && !ack_q && (cyc - 1 - req_edge) != 3)
        flag_mismatch("load_ack rise latency", 3, cyc - 1 - req_edge);
      if (!load_req && req_q && load_ack) low_edge = cyc;
      if (!load_ack && ack_q && (cyc - 1 - low_edge) != 1)
        flag_mismatch("load_ack fall latency", 1, cyc - 1 - low_edge);

      ////////////////////////////////////////
      // clock enables
      ////////////////////////////////////////
      if (core_tick_2x) fast_ticks++;
      if (core_tick) begin
        if (!core_tick_2x) flag_mismatch("core_tick_2x with core_tick", 1, 0);
        if (last_tick >= 0) begin
          if (cyc - last_tick != div_reload + 1)
            flag_mismatch("core_tick period", div_reload + 1, cyc - last_tick);
          if (fast_ticks != 2) flag_mismatch("core_tick_2x per period", 2, fast_ticks);
        end
        last_tick  = cyc;
        fast_ticks = 0;
      end

      // golden expectations strobed in by the driver
      if (rom_chk && rom_data !== exp_value)
        flag_mismatch("rom_data", exp_value, rom_data);
      if (key_chk && input_k0 !== exp_value[3:0])
        flag_mismatch("input_k0", exp_value[3:0], input_k0);

      ////////////////////////////////////////
      // video
      ////////////////////////////////////////
      next_addr = addr_q + 8'd1;
      exp_rgb   = (data_q != 4'h0) ? grey : 24'h0;
      if (video_de) begin
        de_cycles++;
        if (video_rgb !== exp_rgb) flag_mismatch("video_rgb", exp_rgb, video_rgb);
        if (video_addr !== next_addr) flag_mismatch("video_addr", next_addr, video_addr);
      end else begin
        if (video_rgb !== 24'h0) flag_mismatch("video_rgb outside de", 0, video_rgb);
        if (video_addr !== addr_q) flag_mismatch("video_addr outside de", addr_q, video_addr);
      end
      if (video_hs) begin
        if (last_hs >= 0 && cyc - last_hs != h_total)
          flag_mismatch("video_hs period", h_total, cyc - last_hs);
        last_hs = cyc;
      end
      // de count is per frame, vs to vs
      if (video_vs) begin
        if (last_vs >= 0) begin
          if (cyc - last_vs != h_total * v_total)
            flag_mismatch("video_vs period", h_total * v_total, cyc - last_vs);
          if (de_cycles != h_active * v_active)
            flag_mismatch("video_de per frame", h_active * v_active, de_cycles);
        end
        last_vs   = cyc;
        de_cycles = 0;
      end
    end
    req_q  = load_req;
    ack_q  = load_ack;
    data_q = video_data;
    addr_q = video_addr;
  end

endmodule

// File: hw/calc_core_top.sv
// calculator core support fabric, top level
// clock enables, rom loader and store, key conditioner and video
// around an external 4 bit cpu, all on the core clock

module calc_core_top #(
  parameter int div_reload = 100,
  parameter int h_total    = 400,
  parameter int h_active   = 320,
  parameter int h_bporch   = 10,
  parameter int v_total    = 512,
  parameter int v_active   = 240,
  parameter int v_bporch   = 10
) (
  input  logic                            clk_3_276mhz,
  input  logic                            reset_n,
  // host load port
  input  logic                            load_req,
  input  logic [31:0]                     load_addr,
  input  logic [31:0]                     load_data,
  output logic                            load_ack,
  // cpu clock enables
  output logic                            core_tick,
  output logic                            core_tick_2x,
  // cpu rom port
  input  logic [calc_pkg::rom_addr_w-1:0] rom_addr,
  output calc_pkg::rom_data_t             rom_data,
  // keys
  input  logic [15:0]                     cont1_key,
  output logic [3:0]                      input_k0,
  // video
  output logic [7:0]                      video_addr,
  input  logic [3:0]                      video_data,
  output logic [23:0]                     video_rgb,
  output logic                            video_de,
  output logic                            video_hs,
  output logic                            video_vs
);

  import calc_pkg::*;

  // loader to rom write path
  logic                  rom_wr_en;
  logic [rom_addr_w-1:0] rom_wr_addr;
  rom_word_t             rom_wr_data;

  ////////////////////////////////////////
  // clocking and program store
  ////////////////////////////////////////

  core_tick_gen #(
    .div_reload (div_reload)
  ) u_tick (
    .clk_3_276mhz (clk_3_276mhz),
    .reset_n      (reset_n),
    .core_tick    (core_tick),
    .core_tick_2x (core_tick_2x)
  );

  rom_loader u_loader (
    .clk_3_276mhz (clk_3_276mhz),
    .reset_n      (reset_n),
    .load_req     (load_req),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .load_ack     (load_ack),
    .rom_wr_en    (rom_wr_en),
    .rom_wr_addr  (rom_wr_addr),
    .rom_wr_data  (rom_wr_data)
  );

  rom_store u_rom (
    .clk_3_276mhz (clk_3_276mhz),
    .core_tick    (core_tick),
    .rom_wr_en    (rom_wr_en),
    .rom_wr_addr  (rom_wr_addr),
    .rom_wr_data  (rom_wr_data),
    .rom_addr     (rom_addr),
    .rom_data     (rom_data)
  );

  ////////////////////////////////////////
  // keys and video
  ////////////////////////////////////////

  key_conditioner u_keys (
    .clk_3_276mhz (clk_3_276mhz),
    .reset_n      (reset_n),
    .core_tick    (core_tick),
    .cont1_key    (cont1_key),
    .input_k0     (input_k0)
  );

  video_timing #(
    .h_total  (h_total),
    .h_active (h_active),
    .h_bporch (h_bporch),
    .v_total  (v_total),
    .v_active (v_active),
    .v_bporch (v_bporch)
  ) u_video (
    .clk_3_276mhz (clk_3_276mhz),
    .reset_n      (reset_n),
    .video_data   (video_data),
    .video_addr   (video_addr),
    .video_rgb    (video_rgb),
    .video_de     (video_de),
    .video_hs     (video_hs),
    .video_vs     (video_vs)
  );

endmodule

// File: hw/video_timing.sv
// video timing and pixel generator
// raster counters, sync pulses, data enable and video address,
// grey pixels where the cpu video data is non-zero

module video_timing #(
  parameter int h_total  = 400,
  parameter int h_active = 320,
  parameter int h_bporch = 10,
  parameter int v_total  = 512,
  parameter int v_active = 240,
  parameter int v_bporch = 10
) (
  input  logic        clk_3_276mhz,
  input  logic        reset_n,
  input  logic [3:0]  video_data,
  output logic [7:0]  video_addr,
  output logic [23:0] video_rgb,
  output logic        video_de,
  output logic        video_hs,
  output logic        video_vs
);

  import calc_pkg::*;

  localparam int xw = $clog2(h_total);
  localparam int yw = $clog2(v_total);

  // raster limits at counter width
  localparam logic [xw-1:0] x_last  = xw'(h_total - 1);
  localparam logic [yw-1:0] y_last  = yw'(v_total - 1);
  localparam logic [xw-1:0] x_start = xw'(h_bporch);
  localparam logic [xw-1:0] x_end   = xw'(h_bporch + h_active);
  localparam logic [yw-1:0] y_start = yw'(v_bporch);
  localparam logic [yw-1:0] y_end   = yw'(v_bporch + v_active);

  logic [xw-1:0] x_count;
  logic [yw-1:0] y_count;
  logic          active;

  // inside the visible window
  assign active = (x_count >= x_start) && (x_count < x_end) &&
                  (y_count >= y_start) && (y_count < y_end);

  ////////////////////////////////////////
  // raster and outputs
  ////////////////////////////////////////

  always_ff @(posedge clk_3_276mhz or negedge reset_n) begin
    if (!reset_n) begin
      x_count    <= '0;
      y_count    <= '0;
      video_addr <= 8'h00;
      video_rgb  <= 24'h0;
      video_de   <= 1'b0;
      video_hs   <= 1'b0;
      video_vs   <= 1'b0;
    end else begin
      // one pixel per clock
      if (x_count == x_last) begin
        x_count <= '0;
        y_count <= (y_count == y_last) ? '0 : y_count + 1'b1;
      end else begin
        x_count <= x_count + 1'b1;
      end

      // frame start, top left corner in the back porch
      video_vs <= (x_count == '0) && (y_count == '0);
      // line start, a few clocks after vs
      video_hs <= (x_count == xw'(3));

      video_de  <= active;
      // black outside the window and for zero data
      video_rgb <= (active && video_data != 4'h0) ? pixel_grey : 24'h0;

      // fetch address walks the active pixels, wraps at 256
      if (active) begin
        video_addr <= video_addr + 1'b1;
      end
    end
  end

  // vs sits in the back porch, never in the window
  a_vs_not_de: assert property (@(posedge clk_3_276mhz) disable iff (!reset_n)
    !(video_vs && video_de));

endmodule

// File: hw/key_conditioner.sv
// controller key conditioner
// three stage tick enabled synchronizer on face a, b and x,
// mapped onto the active low K0 nibble of the cpu

module key_conditioner (
  input  logic        clk_3_276mhz,
  input  logic        reset_n,
  input  logic        core_tick,
  input  logic [15:0] cont1_key,
  output logic [3:0]  input_k0
);

  // first two stages carry {face_x, face_b, face_a}
  logic [2:0] key_s1;
  logic [2:0] key_s2;

  // third stage is the output nibble itself
  // bit 3 unused, then a, b, x inverted
  always_ff @(posedge clk_3_276mhz or negedge reset_n) begin
    if (!reset_n) begin
      key_s1   <= 3'b000;
      key_s2   <= 3'b000;
      input_k0 <= 4'h0;
    end else if (core_tick) begin
      key_s1   <= cont1_key[6:4];
      key_s2   <= key_s1;
      // pressed key reads as 0 on the cpu side
      input_k0 <= {1'b0, ~key_s2[0], ~key_s2[1], ~key_s2[2]};
    end
  end

endmodule

// File: hw/rom_store.sv
// program rom store
// 8192 x 16 word array, host write port and a tick gated cpu read port
// cpu sees the low 12 bits of each word

module rom_store (
  input  logic                            clk_3_276mhz,
  input  logic                            core_tick,
  input  logic                            rom_wr_en,
  input  logic [calc_pkg::rom_addr_w-1:0] rom_wr_addr,
  input  calc_pkg::rom_word_t             rom_wr_data,
  input  logic [calc_pkg::rom_addr_w-1:0] rom_addr,
  output calc_pkg::rom_data_t             rom_data
);

  import calc_pkg::*;

  localparam int rom_depth = 1 << rom_addr_w;

  // word array
  rom_word_t mem [rom_depth];

  ////////////////////////////////////////
  // host write side
  ////////////////////////////////////////

  always_ff @(posedge clk_3_276mhz) begin
    if (rom_wr_en) begin
      mem[rom_wr_addr] <= rom_wr_data;
    end
  end

  ////////////////////////////////////////
  // cpu read side
  ////////////////////////////////////////

  // one read per cpu tick
  // value held until the next tick
  always_ff @(posedge clk_3_276mhz) begin
    if (core_tick) begin
      rom_data <= mem[rom_addr][11:0];
    end
  end

endmodule

// File: hw/rom_loader.sv
// host rom loader
// four phase req/ack write port, splits each 32 bit host word
// into two 16 bit rom writes, upper half first

module rom_loader (
  input  logic                           clk_3_276mhz,
  input  logic                           reset_n,
  input  logic                           load_req,
  input  logic [31:0]                    load_addr,
  input  logic [31:0]                    load_data,
  output logic                           load_ack,
  output logic                           rom_wr_en,
  output logic [calc_pkg::rom_addr_w-1:0] rom_wr_addr,
  output calc_pkg::rom_word_t            rom_wr_data
);

  import calc_pkg::*;

  // fsm states
  localparam logic [2:0] st_idle    = 3'd0;
  localparam logic [2:0] st_wr_hi   = 3'd1;
  localparam logic [2:0] st_wr_lo   = 3'd2;
  localparam logic [2:0] st_ack     = 3'd3;
  localparam logic [2:0] st_hold    = 3'd4;
  localparam logic [2:0] st_release = 3'd5;

  logic [2:0]            state;
  host_word_u            word_q;
  logic [rom_addr_w-1:0] base_idx;
  logic                  region_ok;

  ////////////////////////////////////////
  // request capture
  ////////////////////////////////////////

  // payload, taken when a request is accepted
  always_ff @(posedge clk_3_276mhz) begin
    if (state == st_idle && load_req) begin
      word_q.raw <= load_data;
      // byte address bits 13:1 give the word, pair starts even
      base_idx   <= {load_addr[13:2], 1'b0};
      region_ok  <= (load_addr[31:28] == load_region);
    end
  end

  ////////////////////////////////////////
  // handshake fsm
  ////////////////////////////////////////

  // req seen -> hi write -> lo write -> ack up, then wait for req low
  always_ff @(posedge clk_3_276mhz or negedge reset_n) begin
    if (!reset_n) begin
      state    <= st_idle;
      load_ack <= 1'b0;
    end else begin
      case (state)
        st_idle:    if (load_req) state <= st_wr_hi;
        st_wr_hi:   state <= st_wr_lo;
        st_wr_lo:   state <= st_ack;
        st_ack: begin
          load_ack <= 1'b1;
          state    <= st_hold;
        end
        // req may stay high as long as the host likes
        st_hold:    if (!load_req) state <= st_release;
        st_release: begin
          load_ack <= 1'b0;
          state    <= st_idle;
        end
        default:    state <= st_idle;
      endcase
    end
  end

  // write strobe only for rom region addresses
  assign rom_wr_en   = (state == st_wr_hi || state == st_wr_lo) && region_ok;
  // lower half lands one word above the upper half
  assign rom_wr_addr = (state == st_wr_lo) ? base_idx + 1'b1 : base_idx;
  assign rom_wr_data = (state == st_wr_hi) ? word_q.half.upper : word_q.half.lower;

  // ack only answers a live request
  a_ack_needs_req: assert property (@(posedge clk_3_276mhz) disable iff (!reset_n)
    $rose(load_ack) |-> load_req);

  // writes are done before ack goes up
  a_no_wr_in_ack: assert property (@(posedge clk_3_276mhz) disable iff (!reset_n)
    load_ack |-> !rom_wr_en);

endmodule

// File: hw/core_tick_gen.sv
// cpu clock enable generator
// divides the core clock into a slow tick and a double rate tick

module core_tick_gen #(
  parameter int div_reload = 100
) (
  input  logic clk_3_276mhz,
  input  logic reset_n,
  output logic core_tick,
  output logic core_tick_2x
);

  localparam int cnt_w = $clog2(div_reload + 1);

  // reload and midpoint at counter width
  localparam logic [cnt_w-1:0] cnt_reload = cnt_w'(div_reload);
  localparam logic [cnt_w-1:0] cnt_half   = cnt_w'(div_reload / 2);

  logic [cnt_w-1:0] count;

  // down counter, reload after zero
  // period is div_reload + 1 clocks
  always_ff @(posedge clk_3_276mhz or negedge reset_n) begin
    if (!reset_n) begin
      count        <= cnt_reload;
      core_tick    <= 1'b0;
      core_tick_2x <= 1'b0;
    end else begin
      if (count == '0) begin
        count <= cnt_reload;
      end else begin
        count <= count - 1'b1;
      end
      // registered decode, one clock behind the count
      core_tick    <= (count == '0);
      core_tick_2x <= (count == '0) || (count == cnt_half);
    end
  end

  // slow tick always lines up with a fast tick
  a_tick_in_2x: assert property (@(posedge clk_3_276mhz) disable iff (!reset_n)
    core_tick |-> core_tick_2x);

endmodule

// File: hw/calc_pkg.sv
// calculator core support package
// rom geometry, load region, pixel colour and the host word layout
// shared by the loader, rom store, video generator and top level

package calc_pkg;

  ////////////////////////////////////////
  // program rom geometry
  ////////////////////////////////////////

  // 8192 words of program store
  localparam int rom_addr_w = 13;

  // one stored rom word
  typedef logic [15:0] rom_word_t;

  // cpu only sees the low 12 bits of each word
  typedef logic [11:0] rom_data_t;

  ////////////////////////////////////////
  // host load window
  ////////////////////////////////////////

  // upper address nibble that selects the rom
  localparam logic [3:0] load_region = 4'h0;

  // host word, big endian halfword order
  // upper half goes to the even rom index
  typedef struct packed {
    rom_word_t upper;
    rom_word_t lower;
  } rom_pair_t;

  // same 32 bits seen raw or as a halfword pair
  typedef union packed {
    logic [31:0] raw;
    rom_pair_t   half;
  } host_word_u;

  ////////////////////////////////////////
  // video
  ////////////////////////////////////////

  // lit pixel, 0x3c in each channel
  localparam logic [23:0] pixel_grey = 24'h3c3c3c;

endpackage
